// File: Makefile
VERILATOR  := verilator
TOP        := dcache_tb
FILELIST   := all.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
verilog/dcache_pkg.sv
verilog/cache_way.sv
verilog/plru_tree.sv
verilog/dcache_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
testbench/dcache_tb.sv

// File: testbench/dcache_tb.sv
// random loads and stores against a reference cache; assumes set_bits 4 and four ways
`default_nettype none

module dcache_tb;
  import dcache_pkg::*;

  localparam int num_requests = 600;
  localparam int stall_limit  = 200;

  logic      clock;
  logic      reset;
  cpu_req_t  cpu_req;
  logic      cpu_req_valid;
  logic      cpu_req_ready;
  cpu_resp_t cpu_resp;
  logic      cpu_resp_valid;
  logic      cpu_resp_ready;
  mem_req_t  mem_req;
  logic      mem_req_valid;
  logic      mem_req_ready;
  word_t     mem_resp_data;
  logic      mem_resp_valid;

  // reference cache, 16 sets of 4 ways; tree bits held as {a, b, c}
  logic        ref_valid [16][4];
  logic        ref_dirty [16][4];
  logic [24:0] ref_tag   [16][4];
  word_t       ref_data  [16][4];
  logic [2:0]  ref_tree  [16];

  word_t mem_words [addr_t];
  word_t latest    [addr_t];

  logic [31:0] lfsr;
  int          errors;
  int          done_count;
  int          stall;
  int          since;
  int          resp_wait;
  logic        busy;
  logic        is_load;
  logic        exp_hit;
  logic        resp_seen;
  logic        timed_out;
  logic        wb_pending;
  logic        rd_pending;
  logic        prev_mem_stall;
  logic        prev_resp_stall;
  addr_t       wb_addr;
  addr_t       rd_addr;
  addr_t       resp_addr;
  word_t       wb_data;
  word_t       exp_data;
  mem_req_t    prev_mem_req;
  cpu_resp_t   prev_resp;

  dcache_top #(
    .set_bits(4)
  ) dcache_top_inst (
    .clock         (clock),
    .reset         (reset),
    .cpu_req       (cpu_req),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req_ready (cpu_req_ready),
    .cpu_resp      (cpu_resp),
    .cpu_resp_valid(cpu_resp_valid),
    .cpu_resp_ready(cpu_resp_ready),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_resp_data (mem_resp_data),
    .mem_resp_valid(mem_resp_valid)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic word_t mem_read(input addr_t a);
    if (mem_words.exists(a)) begin
      return mem_words[a];
    end
    return {~a, a};
  endfunction

  function automatic word_t expected_load(input addr_t a);
    if (latest.exists(a)) begin
      return latest[a];
    end
    return {~a, a};
  endfunction

  // hit or victim, expected memory traffic, then the model update
  task automatic predict_request(input cpu_req_t r);
    addr_t       la;
    logic [3:0]  s;
    logic [24:0] t;
    int          way;
    logic [1:0]  w;
    la  = {r.addr[31:3], 3'b000};
    s   = la[6:3];
    t   = la[31:7];
    way = -1;
    for (int i = 0; i < 4; i++) begin
      if (ref_valid[s][i] && ref_tag[s][i] == t) begin
        way = i;
      end
    end
    exp_hit  = (way >= 0);
    is_load  = !r.write;
    exp_data = expected_load(la);
    if (exp_hit) begin
      w = 2'(way);
    end else begin
      w = ref_tree[s][2] ? {1'b1, ref_tree[s][0]} : {1'b0, ref_tree[s][1]};
      if (ref_valid[s][w] && ref_dirty[s][w]) begin
        wb_pending = 1'b1;
        wb_addr    = {ref_tag[s][w], s, 3'b000};
        wb_data    = ref_data[s][w];
      end
      rd_pending = !r.write;
      rd_addr    = la;
    end
    if (r.write) begin
      latest[la]     = r.data;
      ref_data[s][w]  = r.data;
      ref_dirty[s][w] = 1'b1;
    end else if (!exp_hit) begin
      ref_data[s][w]  = exp_data;
      ref_dirty[s][w] = 1'b0;
    end
    ref_valid[s][w] = 1'b1;
    ref_tag[s][w]   = t;
    if (w[1]) begin
      ref_tree[s][2] = 1'b0;
      ref_tree[s][0] = ~w[0];
    end else begin
      ref_tree[s][2] = 1'b1;
      ref_tree[s][1] = ~w[0];
    end
  endtask

  task automatic close_request();
    assert (!wb_pending && !rd_pending) else begin
      errors++;
      $display("request finished without its expected memory access");
    end
    busy       = 1'b0;
    wb_pending = 1'b0;
    rd_pending = 1'b0;
    stall      = 0;
    done_count++;
  endtask

  task automatic drive_cycle();
    cpu_req_t    next_req;
    logic [31:0] t;
    logic [31:0] s;
    logic [31:0] o;
    cpu_resp_ready <= take_bits(2) != 32'd0;
    mem_req_ready  <= take_bits(2) != 32'd0;
    mem_resp_valid <= 1'b0;
    if (resp_wait > 0) begin
      resp_wait--;
      if (resp_wait == 0) begin
        mem_resp_valid <= 1'b1;
        mem_resp_data  <= mem_read(resp_addr);
      end
    end
    if (busy) begin
      cpu_req_valid <= 1'b0;
    end else if (!cpu_req_valid && take_bits(1) != 32'd0) begin
      next_req.write = take_bits(1) != 32'd0;
      t = take_bits(2);
      s = take_bits(2);
      o = take_bits(3);
      // tag bit 9 flips every 32 requests so older lines get evicted
      next_req.addr = {22'd0, done_count[5], t[1:0], 2'b00, s[1:0], o[2:0]};
      next_req.data[63:32] = take_bits(32);
      next_req.data[31:0]  = take_bits(32);
      cpu_req       <= next_req;
      cpu_req_valid <= 1'b1;
    end
  endtask

  task automatic check_cycle();
    stall++;
    if (busy) begin
      since++;
    end
    if (prev_mem_stall) begin
      assert (mem_req_valid && mem_req == prev_mem_req) else begin
        errors++;
        $display("error mem_req_hold: expected %h actual %h", prev_mem_req, mem_req);
      end
    end
    prev_mem_stall = mem_req_valid && !mem_req_ready;
    prev_mem_req   = mem_req;
    if (mem_req_valid && mem_req_ready) begin
      if (mem_req.write) begin
        assert (wb_pending) else begin
          errors++;
          $display("memory write to %h while the victim was clean", mem_req.addr);
        end
        if (wb_pending) begin
          assert (mem_req.addr == wb_addr) else begin
            errors++;
            $display("error writeback_addr: expected %h actual %h", wb_addr, mem_req.addr);
          end
          assert (mem_req.data == wb_data) else begin
            errors++;
            $display("error writeback_data: expected %h actual %h", wb_data, mem_req.data);
          end
        end
        mem_words[mem_req.addr] = mem_req.data;
        wb_pending = 1'b0;
      end else begin
        assert (rd_pending && !wb_pending) else begin
          errors++;
          $display("memory read to %h was not expected at this point", mem_req.addr);
        end
        assert (mem_req.addr == rd_addr) else begin
          errors++;
          $display("error fill_addr: expected %h actual %h", rd_addr, mem_req.addr);
        end
        rd_pending = 1'b0;
        resp_addr  = mem_req.addr;
        resp_wait  = 1 + int'(take_bits(2));
      end
    end
    if (busy && is_load) begin
      assert (!cpu_req_ready) else begin
        errors++;
        $display("cpu_req_ready rose before the load response was taken");
      end
    end
    if (prev_resp_stall) begin
      assert (cpu_resp_valid && cpu_resp == prev_resp) else begin
        errors++;
        $display("error resp_hold: expected %h actual %h", prev_resp, cpu_resp);
      end
    end
    prev_resp_stall = cpu_resp_valid && !cpu_resp_ready;
    prev_resp       = cpu_resp;
    if (cpu_req_valid && cpu_req_ready) begin
      predict_request(cpu_req);
      busy      = 1'b1;
      since     = 0;
      stall     = 0;
      resp_seen = 1'b0;
    end else if (busy && !is_load && since > 0 && cpu_req_ready) begin
      if (exp_hit) begin
        assert (since == 2) else begin
          errors++;
          $display("error store_hit_latency: expected 2 actual %0d", since);
        end
      end
      close_request();
    end
    if (cpu_resp_valid) begin
      assert (busy && is_load) else begin
        errors++;
        $display("response valid with no load outstanding");
      end
      if (!resp_seen) begin
        resp_seen = 1'b1;
        if (exp_hit) begin
          assert (since == 2) else begin
            errors++;
            $display("error load_hit_latency: expected 2 actual %0d", since);
          end
        end
        assert (cpu_resp.data == exp_data) else begin
          errors++;
          $display("error load_data: expected %h actual %h", exp_data, cpu_resp.data);
        end
        assert (cpu_resp.hit == exp_hit) else begin
          errors++;
          $display("error hit_flag: expected %h actual %h", exp_hit, cpu_resp.hit);
        end
      end
      if (cpu_resp_ready) begin
        close_request();
      end
    end
    assert (stall <= stall_limit) else begin
      $display("no progress for %0d cycles, the request or memory handshake hung", stall_limit);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    lfsr            = 32'hdc7c_5190;
    errors          = 0;
    done_count      = 0;
    stall           = 0;
    since           = 0;
    resp_wait       = 0;
    busy            = 1'b0;
    is_load         = 1'b0;
    exp_hit         = 1'b0;
    resp_seen       = 1'b0;
    timed_out       = 1'b0;
    wb_pending      = 1'b0;
    rd_pending      = 1'b0;
    prev_mem_stall  = 1'b0;
    prev_resp_stall = 1'b0;
    for (int s = 0; s < 16; s++) begin
      ref_tree[s] = 3'b000;
      for (int w = 0; w < 4; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_dirty[s][w] = 1'b0;
      end
    end
    reset          <= 1'b1;
    cpu_req        <= '0;
    cpu_req_valid  <= 1'b0;
    cpu_resp_ready <= 1'b0;
    mem_req_ready  <= 1'b0;
    mem_resp_data  <= '0;
    mem_resp_valid <= 1'b0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    assert (cpu_req_ready && !cpu_resp_valid && !mem_req_valid) else begin
      errors++;
      $display("handshake outputs not in their idle state after reset");
    end
    while (done_count < num_requests && !timed_out) begin
      @(posedge clock);
      drive_cycle();
      @(negedge clock);
      check_cycle();
    end
    $display("%0d errors, %0d requests completed", errors, done_count);
    if (errors == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/cache_way.sv
// one cache way; address bits 2:0 are ignored, only valid and dirty are cleared by reset
`default_nettype none

module cache_way #(
  parameter int set_bits = 4
) (
  input  logic              clock,
  input  logic              reset,
  input  dcache_pkg::addr_t lookup_addr,
  input  logic              write_en,
  input  dcache_pkg::word_t write_data,
  input  logic              write_dirty,
  output logic              hit,
  output dcache_pkg::word_t read_data,
  output logic              line_valid,
  output logic              line_dirty,
  output dcache_pkg::addr_t line_addr
);
  import dcache_pkg::*;

  localparam int tag_bits = 32 - 3 - set_bits;
  localparam int num_sets = 1 << set_bits;

  logic [set_bits-1:0] set_index;
  logic [tag_bits-1:0] lookup_tag;

  logic                valid_q [num_sets];
  logic                dirty_q [num_sets];
  logic [tag_bits-1:0] tag_q   [num_sets];
  word_t               data_q  [num_sets];

  assign set_index  = lookup_addr[3 +: set_bits];
  assign lookup_tag = lookup_addr[31 -: tag_bits];

  assign hit        = valid_q[set_index] && (tag_q[set_index] == lookup_tag);
  assign read_data  = data_q[set_index];
  assign line_valid = valid_q[set_index];
  assign line_dirty = dirty_q[set_index];

  // stored line rebuilt with a zero offset
  assign line_addr  = {tag_q[set_index], set_index, 3'b000};

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_sets; i++) begin
        valid_q[i] <= 1'b0;
        dirty_q[i] <= 1'b0;
      end
    end else if (write_en) begin
      valid_q[set_index] <= 1'b1;
      dirty_q[set_index] <= write_dirty;
    end
  end

  always_ff @(posedge clock) begin
    if (write_en) begin
      tag_q[set_index]  <= lookup_tag;
      data_q[set_index] <= write_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/dcache_array.sv
// four ways plus replacement; hit, data and victim are combinational from lookup_addr
`default_nettype none

module dcache_array #(
  parameter int set_bits = 4
) (
  input  logic                clock,
  input  logic                reset,
  input  dcache_pkg::addr_t   lookup_addr,
  input  logic                write_en,
  input  dcache_pkg::word_t   write_data,
  input  logic                write_dirty,
  input  logic                touch,
  output logic                hit,
  output dcache_pkg::word_t   hit_data,
  output dcache_pkg::victim_t victim
);
  import dcache_pkg::*;

  logic [num_ways-1:0] way_hit;
  logic [num_ways-1:0] way_we;
  logic [num_ways-1:0] way_valid;
  logic [num_ways-1:0] way_dirty;
  word_t               way_data [num_ways];
  addr_t               way_addr [num_ways];

  logic [set_bits-1:0] set_index;
  logic [1:0]          hit_way;
  logic [1:0]          victim_way;
  logic [1:0]          used_way;
  logic                plru_update;

  for (genvar i = 0; i < num_ways; i++) begin : gen_way
    cache_way #(
      .set_bits(set_bits)
    ) cache_way_inst (
      .clock      (clock),
      .reset      (reset),
      .lookup_addr(lookup_addr),
      .write_en   (way_we[i]),
      .write_data (write_data),
      .write_dirty(write_dirty),
      .hit        (way_hit[i]),
      .read_data  (way_data[i]),
      .line_valid (way_valid[i]),
      .line_dirty (way_dirty[i]),
      .line_addr  (way_addr[i])
    );
  end

  // at most one way can hit
  always_comb begin
    hit_way = 2'd0;
    for (int w = 0; w < num_ways; w++) begin
      if (way_hit[w]) begin
        hit_way = 2'(w);
      end
    end
  end

  assign hit      = |way_hit;
  assign hit_data = way_data[hit_way];

  // writes go to the hit way, else to the victim
  assign used_way = hit ? hit_way : victim_way;

  always_comb begin
    way_we           = '0;
    way_we[used_way] = write_en;
  end

  assign victim.valid = way_valid[victim_way];
  assign victim.dirty = way_dirty[victim_way];
  assign victim.addr  = way_addr[victim_way];
  assign victim.data  = way_data[victim_way];

  assign set_index   = lookup_addr[3 +: set_bits];
  assign plru_update = write_en || (touch && hit);

  plru_tree #(
    .set_bits(set_bits)
  ) plru_tree_inst (
    .clock     (clock),
    .reset     (reset),
    .set_index (set_index),
    .update    (plru_update),
    .used_way  (used_way),
    .victim_way(victim_way)
  );

endmodule

`default_nettype wire

// File: verilog/dcache_ctrl.sv
// one request at a time; mem_resp_valid must only pulse after an accepted read
`default_nettype none

module dcache_ctrl #(
  parameter int set_bits = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  dcache_pkg::cpu_req_t  cpu_req,
  input  logic                  cpu_req_valid,
  output logic                  cpu_req_ready,
  output dcache_pkg::cpu_resp_t cpu_resp,
  output logic                  cpu_resp_valid,
  input  logic                  cpu_resp_ready,
  output dcache_pkg::mem_req_t  mem_req,
  output logic                  mem_req_valid,
  input  logic                  mem_req_ready,
  input  dcache_pkg::word_t     mem_resp_data,
  input  logic                  mem_resp_valid,
  output dcache_pkg::addr_t     lookup_addr,
  output logic                  write_en,
  output dcache_pkg::word_t     write_data,
  output logic                  write_dirty,
  output logic                  touch,
  input  logic                  hit,
  input  dcache_pkg::word_t     hit_data,
  input  dcache_pkg::victim_t   victim
);
  import dcache_pkg::*;

  localparam int tag_bits = 32 - 3 - set_bits;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_writeback,
    st_fill_req,
    st_fill_wait,
    st_respond
  } state_t;

  state_t    state_q;
  state_t    state_d;
  cpu_req_t  req_q;
  cpu_resp_t resp_q;
  addr_t     line_addr;

  assign line_addr   = {req_q.addr[31 -: tag_bits], req_q.addr[3 +: set_bits], 3'b000};
  assign lookup_addr = line_addr;

  assign cpu_req_ready  = (state_q == st_idle);
  assign cpu_resp_valid = (state_q == st_respond);
  assign cpu_resp       = resp_q;

  // victim is stable while waiting, so the request holds
  assign mem_req_valid = (state_q == st_writeback) || (state_q == st_fill_req);
  assign mem_req       = (state_q == st_writeback) ? {1'b1, victim.addr, victim.data}
                                                   : {1'b0, line_addr, 64'd0};

  // fills install clean, stores install dirty
  assign write_data  = (state_q == st_fill_wait) ? mem_resp_data : req_q.data;
  assign write_dirty = req_q.write;

  always_comb begin
    state_d  = state_q;
    write_en = 1'b0;
    touch    = 1'b0;
    case (state_q)
      st_idle: begin
        if (cpu_req_valid) begin
          state_d = st_lookup;
        end
      end
      st_lookup: begin
        if (hit && !req_q.write) begin
          touch   = 1'b1;
          state_d = st_respond;
        end else if (!hit && victim.valid && victim.dirty) begin
          state_d = st_writeback;
        end else if (req_q.write) begin
          // store hit or store miss over a clean line
          write_en = 1'b1;
          state_d  = st_idle;
        end else begin
          state_d = st_fill_req;
        end
      end
      st_writeback: begin
        if (mem_req_ready) begin
          if (req_q.write) begin
            write_en = 1'b1;
            state_d  = st_idle;
          end else begin
            state_d = st_fill_req;
          end
        end
      end
      st_fill_req: begin
        if (mem_req_ready) begin
          state_d = st_fill_wait;
        end
      end
      st_fill_wait: begin
        if (mem_resp_valid) begin
          write_en = 1'b1;
          state_d  = st_respond;
        end
      end
      st_respond: begin
        if (cpu_resp_ready) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clock) begin
    if (cpu_req_valid && cpu_req_ready) begin
      req_q <= cpu_req;
    end
    if (state_q == st_lookup && hit) begin
      resp_q <= {hit_data, 1'b1};
    end else if (state_q == st_fill_wait && mem_resp_valid) begin
      resp_q <= {mem_resp_data, 1'b0};
    end
  end

endmodule

`default_nettype wire

// File: verilog/dcache_pkg.sv
// cache types; a line is one 64-bit word and the way count is fixed at four
`default_nettype none

package dcache_pkg;

  // the replacement tree only covers four ways
  localparam int num_ways = 4;

  typedef logic [31:0] addr_t;
  typedef logic [63:0] word_t;

  // load or store from the processor
  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t data;
  } cpu_req_t;

  // loads only
  typedef struct packed {
    word_t data;
    logic  hit;
  } cpu_resp_t;

  // line read or writeback
  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t data;
  } mem_req_t;

  // replacement candidate in the looked-up set
  typedef struct packed {
    logic  valid;
    logic  dirty;
    addr_t addr;
    word_t data;
  } victim_t;

endpackage

`default_nettype wire

// File: verilog/dcache_top.sv
// data cache top; set count is 2**set_bits, lines are single 64-bit words
`default_nettype none

module dcache_top #(
  parameter int set_bits = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  dcache_pkg::cpu_req_t  cpu_req,
  input  logic                  cpu_req_valid,
  output logic                  cpu_req_ready,
  output dcache_pkg::cpu_resp_t cpu_resp,
  output logic                  cpu_resp_valid,
  input  logic                  cpu_resp_ready,
  output dcache_pkg::mem_req_t  mem_req,
  output logic                  mem_req_valid,
  input  logic                  mem_req_ready,
  input  dcache_pkg::word_t     mem_resp_data,
  input  logic                  mem_resp_valid
);
  import dcache_pkg::*;

  addr_t   lookup_addr;
  logic    write_en;
  word_t   write_data;
  logic    write_dirty;
  logic    touch;
  logic    hit;
  word_t   hit_data;
  victim_t victim;

  dcache_ctrl #(
    .set_bits(set_bits)
  ) dcache_ctrl_inst (
    .clock         (clock),
    .reset         (reset),
    .cpu_req       (cpu_req),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req_ready (cpu_req_ready),
    .cpu_resp      (cpu_resp),
    .cpu_resp_valid(cpu_resp_valid),
    .cpu_resp_ready(cpu_resp_ready),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_resp_data (mem_resp_data),
    .mem_resp_valid(mem_resp_valid),
    .lookup_addr   (lookup_addr),
    .write_en      (write_en),
    .write_data    (write_data),
    .write_dirty   (write_dirty),
    .touch         (touch),
    .hit           (hit),
    .hit_data      (hit_data),
    .victim        (victim)
  );

  dcache_array #(
    .set_bits(set_bits)
  ) dcache_array_inst (
    .clock      (clock),
    .reset      (reset),
    .lookup_addr(lookup_addr),
    .write_en   (write_en),
    .write_data (write_data),
    .write_dirty(write_dirty),
    .touch      (touch),
    .hit        (hit),
    .hit_data   (hit_data),
    .victim     (victim)
  );

endmodule

`default_nettype wire

// File: verilog/plru_tree.sv
// three-bit tree pseudo-LRU per set, four ways only; all sets point at way 0 after reset
`default_nettype none

module plru_tree #(
  parameter int set_bits = 4
) (
  input  logic                clock,
  input  logic                reset,
  input  logic [set_bits-1:0] set_index,
  input  logic                update,
  input  logic [1:0]          used_way,
  output logic [1:0]          victim_way
);

  localparam int num_sets = 1 << set_bits;

  // a picks the half, b and c pick within the lower and upper half
  typedef struct packed {
    logic a;
    logic b;
    logic c;
  } tree_t;

  tree_t tree_q [num_sets];
  tree_t cur;
  tree_t nxt;

  assign cur = tree_q[set_index];

  assign victim_way = {cur.a, cur.a ? cur.c : cur.b};

  always_comb begin
    nxt = cur;
    if (used_way[1]) begin
      // upper half used, point away from it
      nxt.a = 1'b0;
      nxt.c = ~used_way[0];
    end else begin
      nxt.a = 1'b1;
      nxt.b = ~used_way[0];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_sets; i++) begin
        tree_q[i] <= '0;
      end
    end else if (update) begin
      tree_q[set_index] <= nxt;
    end
  end

endmodule

`default_nettype wire
